/* Makefile */
TOP := tb_burst_splitter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): burst_splitter.f $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f burst_splitter.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Test failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "Run ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* burst_splitter.f */
logic/burst_split_pkg.sv
logic/ax_splitter.sv
logic/burst_len_fifo.sv
logic/burst_resp_ctrl.sv
logic/burst_splitter.sv
tests/tb_burst_splitter_assertions.sv
tests/tb_burst_splitter.sv

/* logic/ax_splitter.sv */
/*
  Address channel splitter
  Accepts one AXI address burst and emits it downstream as a series of
  single-beat requests, stepping the address for INCR bursts. Each accepted
  burst records its length in the response queue for that direction.
*/

`timescale 1ns/1ps
`default_nettype none

module ax_splitter (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  // Upstream address channel
  input  wire burst_split_pkg::ax_chan_t ax_i,
  input  wire logic                      ax_valid_i,
  output logic                           ax_ready_o,
  // Downstream single-beat requests
  output burst_split_pkg::ax_chan_t      ax_o,
  output logic                           ax_valid_o,
  input  wire logic                      ax_ready_i,
  // Length queue interface
  input  wire logic                      len_full_i,
  output logic                           len_push_o,
  output burst_split_pkg::len_t          len_o
);

  import burst_split_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e   state_d, state_q;
  // Remaining part of the burst, len counts beats left minus one
  ax_chan_t ax_d, ax_q;

  // Advance to the following beat of a burst
  function automatic ax_chan_t next_beat(ax_chan_t ax);
    ax_chan_t nxt;
    nxt = ax;
    nxt.len = ax.len - len_t'(1);
    // FIXED bursts stay on one address
    if (ax.burst == BURST_INCR) begin
      nxt.addr = ax.addr + (addr_t'(1) << ax.size);
    end
    return nxt;
  endfunction

  // The queue always records the len of the burst on the upstream port
  assign len_o = ax_i.len;

  // ------------------------------------------------------------------
  // Split FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    ax_d       = ax_q;
    ax_o       = ax_q;
    ax_o.len   = '0;
    ax_valid_o = 1'b0;
    ax_ready_o = 1'b0;
    len_push_o = 1'b0;

    case (state_q)
      IDLE: begin
        // No room to record the length, hold upstream off
        if (ax_valid_i && !len_full_i) begin
          if (ax_i.len == '0) begin
            // Already a single beat, straight through
            ax_o       = ax_i;
            ax_valid_o = 1'b1;
            ax_ready_o = ax_ready_i;
            len_push_o = ax_ready_i;
          end else begin
            // Take the whole burst now and offer its first beat
            ax_ready_o = 1'b1;
            len_push_o = 1'b1;
            ax_o       = ax_i;
            ax_o.len   = '0;
            ax_valid_o = 1'b1;
            ax_d       = ax_i;
            state_d    = BUSY;
            if (ax_ready_i) begin
              ax_d = next_beat(ax_i);
            end
          end
        end
      end

      BUSY: begin
        // One beat per accepted downstream handshake
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = IDLE;
          end else begin
            ax_d = next_beat(ax_q);
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

`default_nettype wire

/* logic/burst_len_fifo.sv */
/*
  Burst length queue
  Keeps the lengths of outstanding bursts in request order. The head entry
  counts down once per completed response beat and leaves the queue after
  its final beat.
*/

`timescale 1ns/1ps
`default_nettype none

module burst_len_fifo #(
  parameter int unsigned Depth = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  // New burst from the address splitter
  input  wire logic                  push_i,
  input  wire burst_split_pkg::len_t len_i,
  output logic                       full_o,
  // Head of queue toward the response control
  input  wire logic                  beat_done_i,
  output logic                       head_valid_o,
  output burst_split_pkg::len_t      head_rem_o
);

  import burst_split_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  len_t mem_q [Depth];
  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t count_q;

  logic head_dec;
  logic pop;

  // Step a pointer around the ring
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign head_valid_o = (count_q != '0);
  assign full_o       = (count_q == cnt_t'(Depth));
  assign head_rem_o   = mem_q[rd_ptr_q];

  // A completed beat either counts the head down or retires it
  assign head_dec = beat_done_i && head_valid_o;
  assign pop      = head_dec && (head_rem_o == '0);

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Push and pop together leave the count alone
      if (push_i && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push_i) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  // ------------------------------------------------------------------
  // Length storage
  // ------------------------------------------------------------------
  // Pushes never land on a full queue, so the write slot is never the head
  // while beats are still counted
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= len_i;
    end
    if (head_dec && !pop) begin
      mem_q[rd_ptr_q] <= head_rem_o - len_t'(1);
    end
  end

endmodule

`default_nettype wire

/* logic/burst_resp_ctrl.sv */
/*
  Burst response control
  W beats pass with last forced high. R beats get last rebuilt from the
  head of the read length queue. Per-beat B responses of a write burst
  are merged into one upstream B carrying any SLVERR seen in the burst.
*/

`timescale 1ns/1ps
`default_nettype none

module burst_resp_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // Write data
  input  wire burst_split_pkg::w_chan_t slv_w_i,
  input  wire logic                     slv_w_valid_i,
  output logic                          slv_w_ready_o,
  output burst_split_pkg::w_chan_t      mst_w_o,
  output logic                          mst_w_valid_o,
  input  wire logic                     mst_w_ready_i,
  // Write response
  input  wire burst_split_pkg::b_chan_t mst_b_i,
  input  wire logic                     mst_b_valid_i,
  output logic                          mst_b_ready_o,
  output burst_split_pkg::b_chan_t      slv_b_o,
  output logic                          slv_b_valid_o,
  input  wire logic                     slv_b_ready_i,
  // Read data
  input  wire burst_split_pkg::r_chan_t mst_r_i,
  input  wire logic                     mst_r_valid_i,
  output logic                          mst_r_ready_o,
  output burst_split_pkg::r_chan_t      slv_r_o,
  output logic                          slv_r_valid_o,
  input  wire logic                     slv_r_ready_i,
  // Length queue heads
  input  wire logic                     w_head_valid_i,
  input  wire burst_split_pkg::len_t    w_head_rem_i,
  input  wire logic                     r_head_valid_i,
  input  wire burst_split_pkg::len_t    r_head_rem_i,
  // Completed response beats
  output logic                          w_beat_done_o,
  output logic                          r_beat_done_o
);

  import burst_split_pkg::*;

  // Some earlier beat of the current write burst failed
  logic err_q;
  logic err_d;
  // Downstream B belongs to the final beat of the head burst
  logic b_final;
  logic b_is_err;

  // ------------------------------------------------------------------
  // W channel
  // ------------------------------------------------------------------
  always_comb begin
    mst_w_o      = slv_w_i;
    // Every downstream write is a single beat
    mst_w_o.last = 1'b1;
  end

  assign mst_w_valid_o = slv_w_valid_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // ------------------------------------------------------------------
  // B channel
  // ------------------------------------------------------------------
  assign b_final  = (w_head_rem_i == '0);
  assign b_is_err = (mst_b_i.resp == RESP_SLVERR);

  always_comb begin
    slv_b_o       = mst_b_i;
    slv_b_valid_o = 1'b0;
    mst_b_ready_o = 1'b0;
    w_beat_done_o = 1'b0;
    err_d         = err_q;

    if (mst_b_valid_i && w_head_valid_i) begin
      if (!b_final) begin
        // Intermediate beat, absorb it and remember a failure
        mst_b_ready_o = 1'b1;
        w_beat_done_o = 1'b1;
        if (b_is_err) begin
          err_d = 1'b1;
        end
      end else begin
        // Final beat goes upstream with the merged status
        slv_b_valid_o = 1'b1;
        if (err_q) begin
          slv_b_o.resp = RESP_SLVERR;
        end
        mst_b_ready_o = slv_b_ready_i;
        w_beat_done_o = slv_b_ready_i;
        // Next burst starts clean
        if (slv_b_ready_i) begin
          err_d = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_d;
    end
  end

  // ------------------------------------------------------------------
  // R channel
  // ------------------------------------------------------------------
  // Beats only move while a read burst is outstanding
  assign slv_r_valid_o = mst_r_valid_i && r_head_valid_i;
  assign mst_r_ready_o = slv_r_ready_i && r_head_valid_i;

  always_comb begin
    slv_r_o      = mst_r_i;
    // Nothing owed after this beat
    slv_r_o.last = (r_head_rem_i == '0);
  end

  // One count per upstream R handshake
  assign r_beat_done_o = mst_r_valid_i && r_head_valid_i && slv_r_ready_i;

endmodule

`default_nettype wire

/* logic/burst_split_pkg.sv */
/*
  Burst splitter shared definitions
  AXI4 field types, channel structs and the burst and response codes
  used by the address splitters, the length queues and the response control
*/

`default_nettype none

package burst_split_pkg;

  // ------------------------------------------------------------------
  // AXI field types
  // ------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  // Beats in the burst minus one
  typedef logic [7:0]  len_t;
  // log2 of bytes per beat
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [1:0]  resp_t;

  // Burst type codes, WRAP is not handled here
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ------------------------------------------------------------------
  // Channel payloads
  // ------------------------------------------------------------------
  // Shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage

`default_nettype wire

/* logic/burst_splitter.sv */
/*
  AXI4 burst splitter
  Splits FIXED and INCR read and write bursts into single-beat
  transactions. Responses are assumed to return in request order, one
  length queue per direction tracks the bursts in flight.
*/

`timescale 1ns/1ps
`default_nettype none

module burst_splitter #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  // ------------------------------------------------------------------
  // Upstream port
  // ------------------------------------------------------------------
  input  wire burst_split_pkg::ax_chan_t slv_aw_i,
  input  wire logic                      slv_aw_valid_i,
  output logic                           slv_aw_ready_o,
  input  wire burst_split_pkg::w_chan_t  slv_w_i,
  input  wire logic                      slv_w_valid_i,
  output logic                           slv_w_ready_o,
  output burst_split_pkg::b_chan_t       slv_b_o,
  output logic                           slv_b_valid_o,
  input  wire logic                      slv_b_ready_i,
  input  wire burst_split_pkg::ax_chan_t slv_ar_i,
  input  wire logic                      slv_ar_valid_i,
  output logic                           slv_ar_ready_o,
  output burst_split_pkg::r_chan_t       slv_r_o,
  output logic                           slv_r_valid_o,
  input  wire logic                      slv_r_ready_i,
  // ------------------------------------------------------------------
  // Downstream port
  // ------------------------------------------------------------------
  output burst_split_pkg::ax_chan_t      mst_aw_o,
  output logic                           mst_aw_valid_o,
  input  wire logic                      mst_aw_ready_i,
  output burst_split_pkg::w_chan_t       mst_w_o,
  output logic                           mst_w_valid_o,
  input  wire logic                      mst_w_ready_i,
  input  wire burst_split_pkg::b_chan_t  mst_b_i,
  input  wire logic                      mst_b_valid_i,
  output logic                           mst_b_ready_o,
  output burst_split_pkg::ax_chan_t      mst_ar_o,
  output logic                           mst_ar_valid_o,
  input  wire logic                      mst_ar_ready_i,
  input  wire burst_split_pkg::r_chan_t  mst_r_i,
  input  wire logic                      mst_r_valid_i,
  output logic                           mst_r_ready_o
);

  import burst_split_pkg::*;

  // Write side bookkeeping
  logic w_len_push, w_len_full, w_head_valid, w_beat_done;
  len_t w_len, w_head_rem;
  // Read side bookkeeping
  logic r_len_push, r_len_full, r_head_valid, r_beat_done;
  len_t r_len, r_head_rem;

  // AW split and write length queue
  ax_splitter i_aw_splitter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ax_i       (slv_aw_i),
    .ax_valid_i (slv_aw_valid_i),
    .ax_ready_o (slv_aw_ready_o),
    .ax_o       (mst_aw_o),
    .ax_valid_o (mst_aw_valid_o),
    .ax_ready_i (mst_aw_ready_i),
    .len_full_i (w_len_full),
    .len_push_o (w_len_push),
    .len_o      (w_len)
  );

  burst_len_fifo #(
    .Depth (MaxWriteTxns)
  ) i_w_len_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (w_len_push),
    .len_i        (w_len),
    .full_o       (w_len_full),
    .beat_done_i  (w_beat_done),
    .head_valid_o (w_head_valid),
    .head_rem_o   (w_head_rem)
  );

  // AR split and read length queue
  ax_splitter i_ar_splitter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ax_i       (slv_ar_i),
    .ax_valid_i (slv_ar_valid_i),
    .ax_ready_o (slv_ar_ready_o),
    .ax_o       (mst_ar_o),
    .ax_valid_o (mst_ar_valid_o),
    .ax_ready_i (mst_ar_ready_i),
    .len_full_i (r_len_full),
    .len_push_o (r_len_push),
    .len_o      (r_len)
  );

  burst_len_fifo #(
    .Depth (MaxReadTxns)
  ) i_r_len_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (r_len_push),
    .len_i        (r_len),
    .full_o       (r_len_full),
    .beat_done_i  (r_beat_done),
    .head_valid_o (r_head_valid),
    .head_rem_o   (r_head_rem)
  );

  // W, B and R handling
  burst_resp_ctrl i_resp_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .w_head_valid_i (w_head_valid),
    .w_head_rem_i   (w_head_rem),
    .r_head_valid_i (r_head_valid),
    .r_head_rem_i   (r_head_rem),
    .w_beat_done_o  (w_beat_done),
    .r_beat_done_o  (r_beat_done)
  );

endmodule

`default_nettype wire

/* tests/tb_burst_splitter.sv */
/*
  Testbench for the AXI4 burst splitter
  Plays upstream master and downstream slave, applies a table of read
  and write bursts under random ready patterns and checks every beat
*/

`timescale 1ns/1ps
`default_nettype none

module tb_burst_splitter;

  import burst_split_pkg::*;

  localparam int          NUM_ROWS  = 11;
  localparam int          MAX_WAIT  = 1000;
  localparam logic [31:0] SEED      = 32'h4a59_47f9;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // One burst of the stimulus table, err_beat of -1 means no SLVERR
  typedef struct packed {
    logic   is_write;
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    int     err_beat;
  } row_t;

  logic clk_i;
  logic rst_n_i;
  ax_chan_t slv_aw_i, slv_ar_i, mst_aw_o, mst_ar_o;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  w_chan_t slv_w_i, mst_w_o;
  logic slv_w_valid_i, slv_w_ready_o, mst_w_valid_o, mst_w_ready_i;
  b_chan_t mst_b_i, slv_b_o;
  logic mst_b_valid_i, mst_b_ready_o, slv_b_valid_o, slv_b_ready_i;
  r_chan_t mst_r_i, slv_r_o;
  logic mst_r_valid_i, mst_r_ready_o, slv_r_valid_o, slv_r_ready_i;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr;
  // Addresses the downstream model accepted for the current burst
  addr_t       seen_addr [$];

  burst_splitter i_burst_splitter (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Random ready and expected values
  // ------------------------------------------------------------------
  function automatic logic next_random_bit();
    lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    return lfsr[0];
  endfunction

  // Ready about three cycles in four
  function automatic logic random_ready();
    logic b0;
    logic b1;
    b0 = next_random_bit();
    b1 = next_random_bit();
    return b0 | b1;
  endfunction

  // FIXED stays put, INCR steps by 2^size per beat
  function automatic addr_t beat_addr(row_t row, int beat);
    if (row.burst == BURST_FIXED) begin
      return row.addr;
    end
    return row.addr + (addr_t'(beat) << row.size);
  endfunction

  function automatic w_chan_t beat_write(row_t row, int beat);
    w_chan_t w;
    w.data = {~row.addr[31:8], 8'(beat)};
    w.strb = {row.id[1:0], 2'b11};
    w.last = (beat == int'(row.len));
    return w;
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_ax(input string name, input ax_chan_t got, input ax_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_w(input string name, input w_chan_t got, input w_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_r(input string name, input r_chan_t got, input r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_b(input string name, input b_chan_t got, input b_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %b expected %b",
                          $time, name, got, exp));
    end
  endtask

  // Samples at the falling edge, drives 5 ns after the rising edge
  task automatic next_drive_point();
    @(posedge clk_i);
    #5;
  endtask

  // ------------------------------------------------------------------
  // Address phase, upstream burst in and single beats out
  // ------------------------------------------------------------------
  task automatic send_address(input row_t row);
    ax_chan_t up_ax;
    ax_chan_t exp_ax;
    ax_chan_t dn_ax;
    logic     dn_valid;
    logic     dn_ready;
    logic     up_ready;
    logic     exp_up_ready;
    logic     up_done;
    string    valid_name;
    string    ax_name;
    string    ready_name;
    int       beat;
    int       cycles;
    up_ax   = '{id: row.id, addr: row.addr, len: row.len, size: row.size, burst: row.burst};
    up_done = 1'b0;
    beat    = 0;
    cycles  = 0;
    if (row.is_write) begin
      valid_name = "mst_aw_valid_o";
      ax_name    = "mst_aw_o";
      ready_name = "slv_aw_ready_o";
    end else begin
      valid_name = "mst_ar_valid_o";
      ax_name    = "mst_ar_o";
      ready_name = "slv_ar_ready_o";
    end
    seen_addr.delete();
    while (!up_done || beat <= int'(row.len)) begin
      dn_ready = random_ready();
      if (row.is_write) begin
        slv_aw_i       = up_ax;
        slv_aw_valid_i = !up_done;
        mst_aw_ready_i = dn_ready;
      end else begin
        slv_ar_i       = up_ax;
        slv_ar_valid_i = !up_done;
        mst_ar_ready_i = dn_ready;
      end
      @(negedge clk_i);
      dn_valid    = row.is_write ? mst_aw_valid_o : mst_ar_valid_o;
      dn_ax       = row.is_write ? mst_aw_o : mst_ar_o;
      up_ready    = row.is_write ? slv_aw_ready_o : slv_ar_ready_o;
      exp_ax      = up_ax;
      exp_ax.addr = beat_addr(row, beat);
      exp_ax.len  = '0;
      // Single beats wait for downstream ready
      // Longer bursts are taken at once and nothing more while busy
      exp_up_ready = !up_done && ((row.len == 8'd0) ? dn_ready : 1'b1);
      // Beats owed must be offered every cycle
      check_bit(valid_name, dn_valid, 1'b1);
      check_ax(ax_name, dn_ax, exp_ax);
      check_bit(ready_name, up_ready, exp_up_ready);
      if (dn_ready) begin
        seen_addr.push_back(dn_ax.addr);
        beat++;
      end
      if (!up_done && up_ready) begin
        up_done = 1'b1;
      end
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run("address phase did not finish within the wait limit");
      end
      next_drive_point();
    end
    slv_aw_valid_i = 1'b0;
    slv_ar_valid_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Write data and merged write response
  // ------------------------------------------------------------------
  task automatic send_write_data(input row_t row);
    w_chan_t exp_w;
    logic    rdy;
    int      beat;
    int      cycles;
    beat   = 0;
    cycles = 0;
    while (beat <= int'(row.len)) begin
      rdy           = random_ready();
      slv_w_i       = beat_write(row, beat);
      slv_w_valid_i = 1'b1;
      mst_w_ready_i = rdy;
      @(negedge clk_i);
      exp_w      = beat_write(row, beat);
      exp_w.last = 1'b1;
      check_bit("mst_w_valid_o", mst_w_valid_o, 1'b1);
      check_w("mst_w_o", mst_w_o, exp_w);
      check_bit("slv_w_ready_o", slv_w_ready_o, rdy);
      // Extra address beats would show up here
      check_bit("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
      if (rdy) begin
        beat++;
      end
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run("write data phase did not finish within the wait limit");
      end
      next_drive_point();
    end
    slv_w_valid_i = 1'b0;
    mst_w_ready_i = 1'b0;
  endtask

  task automatic return_write_resp(input row_t row);
    b_chan_t exp_b;
    logic    rdy;
    int      beat;
    int      cycles;
    beat       = 0;
    cycles     = 0;
    exp_b.id   = row.id;
    exp_b.resp = (row.err_beat >= 0) ? RESP_SLVERR : RESP_OKAY;
    while (beat <= int'(row.len)) begin
      rdy           = random_ready();
      mst_b_i.id    = row.id;
      mst_b_i.resp  = (beat == row.err_beat) ? RESP_SLVERR : RESP_OKAY;
      mst_b_valid_i = 1'b1;
      slv_b_ready_i = rdy;
      @(negedge clk_i);
      if (beat < int'(row.len)) begin
        // Intermediate beat is absorbed
        check_bit("slv_b_valid_o", slv_b_valid_o, 1'b0);
        check_bit("mst_b_ready_o", mst_b_ready_o, 1'b1);
        beat++;
      end else begin
        check_bit("slv_b_valid_o", slv_b_valid_o, 1'b1);
        check_b("slv_b_o", slv_b_o, exp_b);
        check_bit("mst_b_ready_o", mst_b_ready_o, rdy);
        if (rdy) begin
          beat++;
        end
      end
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run("write response phase did not finish within the wait limit");
      end
      next_drive_point();
    end
    mst_b_valid_i = 1'b0;
    slv_b_ready_i = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Read data, one R per accepted AR carrying its address
  // ------------------------------------------------------------------
  task automatic return_read_data(input row_t row);
    r_chan_t exp_r;
    logic    rdy;
    int      beat;
    int      cycles;
    beat   = 0;
    cycles = 0;
    while (beat <= int'(row.len)) begin
      rdy           = random_ready();
      mst_r_i       = '{id: row.id, data: seen_addr[beat], resp: RESP_OKAY, last: 1'b1};
      mst_r_valid_i = 1'b1;
      slv_r_ready_i = rdy;
      @(negedge clk_i);
      exp_r = '{id: row.id, data: beat_addr(row, beat), resp: RESP_OKAY,
                last: (beat == int'(row.len))};
      check_bit("slv_r_valid_o", slv_r_valid_o, 1'b1);
      check_r("slv_r_o", slv_r_o, exp_r);
      check_bit("mst_r_ready_o", mst_r_ready_o, rdy);
      check_bit("mst_ar_valid_o", mst_ar_valid_o, 1'b0);
      if (rdy) begin
        beat++;
      end
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run("read data phase did not finish within the wait limit");
      end
      next_drive_point();
    end
    mst_r_valid_i = 1'b0;
    slv_r_ready_i = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    lfsr           = SEED;
    rst_n_i        = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    // Columns: is_write, id, addr, len, size, burst, err_beat
    rows = '{
      '{1'b0, 4'h1, 32'h0000_1000, 8'd3,  3'd2, BURST_INCR,  -1},
      '{1'b0, 4'h2, 32'h0000_2040, 8'd2,  3'd2, BURST_FIXED, -1},
      '{1'b0, 4'h3, 32'h0000_3008, 8'd0,  3'd2, BURST_INCR,  -1},
      '{1'b1, 4'h4, 32'h0000_4010, 8'd0,  3'd2, BURST_INCR,  -1},
      '{1'b1, 4'h5, 32'h0000_5000, 8'd3,  3'd2, BURST_INCR,  -1},
      '{1'b1, 4'h6, 32'h0000_6020, 8'd4,  3'd1, BURST_FIXED, 2},
      '{1'b1, 4'h7, 32'h0000_7000, 8'd1,  3'd2, BURST_INCR,  -1},
      '{1'b0, 4'h8, 32'h0000_8001, 8'd7,  3'd0, BURST_INCR,  -1},
      '{1'b1, 4'h9, 32'h0000_9000, 8'd2,  3'd2, BURST_INCR,  2},
      '{1'b0, 4'ha, 32'h0000_a000, 8'd15, 3'd3, BURST_INCR,  -1},
      '{1'b1, 4'hb, 32'h0000_b004, 8'd0,  3'd2, BURST_INCR,  0}
    };
    repeat (3) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      send_address(rows[i]);
      if (rows[i].is_write) begin
        send_write_data(rows[i]);
        return_write_resp(rows[i]);
      end else begin
        return_read_data(rows[i]);
      end
    end

    // Bound assertions that fired during the run
    if (i_burst_splitter.i_assertions.failures == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("%0d assertion failures", i_burst_splitter.i_assertions.failures);
      $display(">>> FAIL");
      $fatal(1, "assertion failures during the run");
    end
  end

endmodule

`default_nettype wire

/* tests/tb_burst_splitter_assertions.sv */
/*
  Burst splitter port assertions
  Bound into the top level, checks single-beat downstream requests,
  forced W last and quiet response channels right after reset
*/

`timescale 1ns/1ps
`default_nettype none

module tb_burst_splitter_assertions (
  input wire logic                      clk_i,
  input wire logic                      rst_n_i,
  input wire burst_split_pkg::ax_chan_t mst_aw_i,
  input wire logic                      mst_aw_valid_i,
  input wire burst_split_pkg::ax_chan_t mst_ar_i,
  input wire logic                      mst_ar_valid_i,
  input wire burst_split_pkg::w_chan_t  mst_w_i,
  input wire logic                      mst_w_valid_i,
  input wire logic                      slv_b_valid_i,
  input wire logic                      slv_r_valid_i
);

  // Failed assertion count, read by the testbench at the end
  int unsigned failures = 0;

  // Downstream requests are always single beats
  aw_single_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_aw_valid_i |-> (mst_aw_i.len == '0))
  else begin
    $error("downstream AW valid with nonzero len");
    failures = failures + 1;
  end

  ar_single_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_i |-> (mst_ar_i.len == '0))
  else begin
    $error("downstream AR valid with nonzero len");
    failures = failures + 1;
  end

  // Every downstream W closes its own transaction
  w_last_forced: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_w_valid_i |-> mst_w_i.last)
  else begin
    $error("downstream W valid without last");
    failures = failures + 1;
  end

  // No response leaks out in the first cycle after reset
  resp_quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!slv_b_valid_i && !slv_r_valid_i))
  else begin
    $error("upstream B or R valid right after reset");
    failures = failures + 1;
  end

endmodule

bind burst_splitter tb_burst_splitter_assertions i_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .mst_aw_i       (mst_aw_o),
  .mst_aw_valid_i (mst_aw_valid_o),
  .mst_ar_i       (mst_ar_o),
  .mst_ar_valid_i (mst_ar_valid_o),
  .mst_w_i        (mst_w_o),
  .mst_w_valid_i  (mst_w_valid_o),
  .slv_b_valid_i  (slv_b_valid_o),
  .slv_r_valid_i  (slv_r_valid_o)
);

`default_nettype wire
